//--- all.f
rtl/perip_pkg.sv
rtl/perip_bridge.sv
rtl/perip_regs.sv
rtl/ms_timer.sv
rtl/seg_scan.sv
rtl/perip_top.sv
testbench/perip_asserts.sv
testbench/perip_tb.sv

//--- rtl/ms_timer.sv
`timescale 1ns/1ps

module ms_timer #(
    parameter int clk_per_ms = 50000
) (
    input  logic                        clk,
    input  logic                        rst_sync,
    input  logic                        cnt_we,
    input  logic [perip_pkg::data_w-1:0] wr_data,
    output logic [perip_pkg::data_w-1:0] cnt_q
);

    import perip_pkg::*;

    // Prescaler width, kept at one bit for a one-cycle millisecond
    localparam int pre_w = (clk_per_ms > 1) ? $clog2(clk_per_ms) : 1;
    localparam logic [pre_w-1:0] pre_max = pre_w'(clk_per_ms - 1);

    logic              run;
    logic [pre_w-1:0]  pre_cnt;
    logic              ms_tick;
    logic [data_w-1:0] cnt_ms;

    ////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////

    // Other words written here leave the run flag alone
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            run <= 1'b0;
        end else if (cnt_we && wr_data == cmd_start) begin
            run <= 1'b1;
        end else if (cnt_we && wr_data == cmd_stop) begin
            run <= 1'b0;
        end
    end

    ////////////////////////////////////////////////
    // Prescaler and millisecond count
    ////////////////////////////////////////////////

    assign ms_tick = run && (pre_cnt == pre_max);

    // Back to zero whenever stopped
    always_ff @(posedge clk) begin
        if (rst_sync || !run || ms_tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Only reset clears the count, start just resumes it
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            cnt_ms <= '0;
        end else if (ms_tick) begin
            cnt_ms <= cnt_ms + 1'b1;
        end
    end

    assign cnt_q = cnt_ms;

endmodule

//--- rtl/perip_bridge.sv
`timescale 1ns/1ps

module perip_bridge (
    input  logic                        clk,
    input  logic                        rst_sync,

    // Request side
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [perip_pkg::addr_w-1:0] req_addr,
    input  logic [perip_pkg::data_w-1:0] req_wdata,

    // Response side
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [perip_pkg::data_w-1:0] rsp_rdata,

    // Peripheral strobes and shared write data
    output logic                        led_we,
    output logic                        seg_we,
    output logic                        cnt_we,
    output logic [perip_pkg::data_w-1:0] wr_data,

    // Readback words
    input  logic [perip_pkg::data_w-1:0] led_q,
    input  logic [perip_pkg::data_w-1:0] seg_q,
    input  logic [perip_pkg::data_w-1:0] sw_q,
    input  logic [perip_pkg::data_w-1:0] cnt_q
);

    import perip_pkg::*;

    logic              accept;
    logic              is_led;
    logic              is_seg;
    logic              is_cnt;
    logic [data_w-1:0] rd_word;

    // One request in flight, so a pending response blocks new ones
    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;

    ////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////

    // Misaligned offsets fall into unmapped space
    always_comb begin
        is_led  = 1'b0;
        is_seg  = 1'b0;
        is_cnt  = 1'b0;
        rd_word = '0;
        case (req_addr)
            addr_led: begin
                is_led  = 1'b1;
                rd_word = led_q;
            end
            addr_seg: begin
                is_seg  = 1'b1;
                rd_word = seg_q;
            end
            addr_sw:  rd_word = sw_q;
            addr_cnt: begin
                is_cnt  = 1'b1;
                rd_word = cnt_q;
            end
            default: rd_word = '0;
        endcase
    end

    // Writes land on the acceptance edge
    assign led_we  = accept && req_write && is_led;
    assign seg_we  = accept && req_write && is_seg;
    assign cnt_we  = accept && req_write && is_cnt;
    assign wr_data = req_wdata;

    ////////////////////////////////////////////////
    // Response register
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Loads only on acceptance, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_rdata <= req_write ? '0 : rd_word;
        end
    end

endmodule

//--- rtl/perip_pkg.sv
package perip_pkg;

    ////////////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////////////

    localparam int data_w = 32;
    localparam int addr_w = 4;

    // LED port width, shared by the switch input
    localparam int led_w = 16;

    ////////////////////////////////////////////////
    // Register map, byte offsets
    ////////////////////////////////////////////////

    localparam logic [addr_w-1:0] addr_led = 4'h0;
    localparam logic [addr_w-1:0] addr_seg = 4'h4;
    localparam logic [addr_w-1:0] addr_sw  = 4'h8;
    localparam logic [addr_w-1:0] addr_cnt = 4'hc;

    // Timer command words, compared whole
    localparam logic [data_w-1:0] cmd_start = 32'h8000_0000;
    localparam logic [data_w-1:0] cmd_stop  = 32'hffff_ffff;

endpackage

//--- rtl/perip_regs.sv
`timescale 1ns/1ps

module perip_regs (
    input  logic                        clk,
    input  logic                        rst_sync,

    // Write strobes from the bridge
    input  logic                        led_we,
    input  logic                        seg_we,
    input  logic [perip_pkg::data_w-1:0] wr_data,

    // Board pins
    input  logic [perip_pkg::led_w-1:0]  sw,
    output logic [perip_pkg::led_w-1:0]  led,

    // Readback words
    output logic [perip_pkg::data_w-1:0] led_q,
    output logic [perip_pkg::data_w-1:0] seg_q,
    output logic [perip_pkg::data_w-1:0] sw_q
);

    import perip_pkg::*;

    logic [led_w-1:0]  led_r;
    logic [data_w-1:0] seg_r;
    logic [led_w-1:0]  sw_meta;
    logic [led_w-1:0]  sw_sync;

    ////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            led_r <= '0;
        end else if (led_we) begin
            led_r <= wr_data[led_w-1:0];
        end
    end

    // Digits show zero until software writes a value
    always_ff @(posedge clk) begin
        if (rst_sync) begin
            seg_r <= '0;
        end else if (seg_we) begin
            seg_r <= wr_data;
        end
    end

    assign led   = led_r;
    assign led_q = {{(data_w - led_w){1'b0}}, led_r};
    assign seg_q = seg_r;

    ////////////////////////////////////////////////
    // Switch synchronizer
    ////////////////////////////////////////////////

    // Two flops make a change readable two cycles later
    always_ff @(posedge clk) begin
        sw_meta <= sw;
        sw_sync <= sw_meta;
    end

    assign sw_q = {{(data_w - led_w){1'b0}}, sw_sync};

endmodule

//--- rtl/perip_top.sv
`timescale 1ns/1ps

module perip_top #(
    parameter int clk_per_ms  = 50000,
    parameter int scan_cycles = 50000
) (
    input  logic                        clk,
    input  logic                        rst_sync,

    // CPU request and response
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [perip_pkg::addr_w-1:0] req_addr,
    input  logic [perip_pkg::data_w-1:0] req_wdata,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [perip_pkg::data_w-1:0] rsp_rdata,

    // Board pins
    input  logic [perip_pkg::led_w-1:0]  sw,
    output logic [perip_pkg::led_w-1:0]  led,
    output logic [7:0]                  an_n,
    output logic [6:0]                  seg_n
);

    import perip_pkg::*;

    logic              led_we;
    logic              seg_we;
    logic              cnt_we;
    logic [data_w-1:0] wr_data;
    logic [data_w-1:0] led_q;
    logic [data_w-1:0] seg_q;
    logic [data_w-1:0] sw_q;
    logic [data_w-1:0] cnt_q;

    perip_bridge perip_bridge_inst (
        .clk, .rst_sync,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .rsp_valid, .rsp_ready, .rsp_rdata,
        .led_we, .seg_we, .cnt_we, .wr_data,
        .led_q, .seg_q, .sw_q, .cnt_q
    );

    perip_regs perip_regs_inst (
        .clk, .rst_sync, .led_we, .seg_we, .wr_data,
        .sw, .led, .led_q, .seg_q, .sw_q
    );

    ms_timer #(.clk_per_ms(clk_per_ms)) ms_timer_inst (
        .clk, .rst_sync, .cnt_we, .wr_data, .cnt_q
    );

    seg_scan #(.scan_cycles(scan_cycles)) seg_scan_inst (
        .clk, .rst_sync, .seg_q, .an_n, .seg_n
    );

endmodule

//--- rtl/seg_scan.sv
`timescale 1ns/1ps

module seg_scan #(
    parameter int scan_cycles = 50000
) (
    input  logic                        clk,
    input  logic                        rst_sync,
    input  logic [perip_pkg::data_w-1:0] seg_q,
    output logic [7:0]                  an_n,
    output logic [6:0]                  seg_n
);

    localparam int dw_w = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;
    localparam logic [dw_w-1:0] dwell_max = dw_w'(scan_cycles - 1);

    logic [dw_w-1:0] dwell;
    logic [2:0]      digit;
    logic [3:0]      nibble;

    // Segment pattern, bit 0 is segment a, active high
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_to_seg = 7'h3f;
            4'h1: hex_to_seg = 7'h06;
            4'h2: hex_to_seg = 7'h5b;
            4'h3: hex_to_seg = 7'h4f;
            4'h4: hex_to_seg = 7'h66;
            4'h5: hex_to_seg = 7'h6d;
            4'h6: hex_to_seg = 7'h7d;
            4'h7: hex_to_seg = 7'h07;
            4'h8: hex_to_seg = 7'h7f;
            4'h9: hex_to_seg = 7'h6f;
            4'ha: hex_to_seg = 7'h77;
            4'hb: hex_to_seg = 7'h7c;
            4'hc: hex_to_seg = 7'h39;
            4'hd: hex_to_seg = 7'h5e;
            4'he: hex_to_seg = 7'h79;
            default: hex_to_seg = 7'h71;
        endcase
    endfunction

    ////////////////////////////////////////////////
    // Dwell timer and digit index
    ////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_sync) begin
            dwell <= '0;
            digit <= 3'd0;
        end else if (dwell == dwell_max) begin
            dwell <= '0;
            // Wraps from 7 back to 0
            digit <= digit + 3'd1;
        end else begin
            dwell <= dwell + 1'b1;
        end
    end

    ////////////////////////////////////////////////
    // Display lines
    ////////////////////////////////////////////////

    assign nibble = seg_q[{digit, 2'b00} +: 4];
    assign an_n   = ~(8'b0000_0001 << digit);
    assign seg_n  = ~hex_to_seg(nibble);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module perip_tb -f all.f -o perip_sim

./obj_dir/perip_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

//--- testbench/perip_asserts.sv
`timescale 1ns/1ps

module perip_asserts (
    input logic                         clk,
    input logic                         rst_sync,
    input logic                         req_ready,
    input logic                         rsp_valid,
    input logic                         rsp_ready,
    input logic [perip_pkg::data_w-1:0] rsp_rdata,
    input logic [7:0]                   an_n
);

    // No response is left over once reset has been seen
    rsp_idle_after_reset: assert property (@(posedge clk) rst_sync |=> !rsp_valid)
        else $error("rsp_valid high in the cycle after reset");

    rsp_held: assert property (@(posedge clk) disable iff (rst_sync)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else $error("response changed before rsp_ready");

    // Single request in flight
    req_blocked: assert property (@(posedge clk) disable iff (rst_sync)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    one_digit: assert property (@(posedge clk) disable iff (rst_sync) $onehot(~an_n))
        else $error("an_n does not select exactly one digit");

endmodule

bind perip_top perip_asserts perip_asserts_inst (
    .clk(clk), .rst_sync(rst_sync), .req_ready(req_ready), .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata), .an_n(an_n)
);

//--- testbench/perip_tb.sv
`timescale 1ns/1ps

module perip_tb;

    import perip_pkg::*;

    localparam int clk_per_ms  = 8;
    localparam int scan_cycles = 4;
    localparam int n_rows      = 27;
    localparam int max_cycles  = n_rows * 64 + 200;

    // Segments gfedcba lit high for hex digits 0 to f
    localparam logic [6:0] seg_tab [16] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
        7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
        7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
        7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001
    };

    logic              clk;
    logic              rst_sync;
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [data_w-1:0] rsp_rdata;
    logic [led_w-1:0]  sw;
    logic [led_w-1:0]  led;
    logic [7:0]        an_n;
    logic [6:0]        seg_n;

    // Stimulus table with one entry per bus transfer
    logic              t_wr    [n_rows];
    logic [addr_w-1:0] t_addr  [n_rows];
    logic [data_w-1:0] t_wdata [n_rows];
    logic [data_w-1:0] t_exp   [n_rows];
    logic [led_w-1:0]  t_sw    [n_rows];
    int                t_idle  [n_rows];
    logic              t_rnd   [n_rows];
    int                t_stall [n_rows];

    int          fill_idx = 0;
    int          cycle = 0;
    int          errors;
    int          rows_failed;
    int          row_errs;
    logic [31:0] rand_state;
    logic [31:0] last_rand;
    // Reference state of the millisecond timer
    logic        tmr_run;
    int          tmr_start;
    logic [31:0] tmr_ms;

    perip_top #(.clk_per_ms(clk_per_ms), .scan_cycles(scan_cycles)) perip_top_inst (
        .clk, .rst_sync,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .rsp_valid, .rsp_ready, .rsp_rdata,
        .sw, .led, .an_n, .seg_n
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= max_cycles);
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input logic wr, input logic [addr_w-1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic [15:0] swv, input int idle,
                           input logic rnd, input int stall);
        t_wr[fill_idx]    = wr;
        t_addr[fill_idx]  = addr;
        t_wdata[fill_idx] = wdata;
        t_exp[fill_idx]   = exp;
        t_sw[fill_idx]    = swv;
        t_idle[fill_idx]  = idle;
        t_rnd[fill_idx]   = rnd;
        t_stall[fill_idx] = stall;
        fill_idx++;
    endtask

    ////////////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////////////

    // Start and stop only act on a change of run state
    task automatic track_timer(input logic [addr_w-1:0] addr, input logic [31:0] data,
                               input int acc);
        if (addr == addr_cnt && data == cmd_start && !tmr_run) begin
            tmr_run   = 1'b1;
            tmr_start = acc;
        end else if (addr == addr_cnt && data == cmd_stop && tmr_run) begin
            tmr_ms  = tmr_ms + (acc - tmr_start) / clk_per_ms;
            tmr_run = 1'b0;
        end
    endtask

    // Watch one full scan of the display
    task automatic check_display(input logic [31:0] word);
        logic [7:0] seen;
        logic [6:0] exp_seg;
        int         k;
        int         lows;
        seen = '0;
        repeat (8 * scan_cycles) begin
            @(negedge clk);
            lows = 0;
            k = 0;
            for (int j = 0; j < 8; j++) begin
                if (!an_n[j]) begin
                    lows++;
                    k = j;
                end
            end
            if (lows != 1) begin
                $display("Display lit %0d digits at once at %0d ns", lows, $time);
                row_errs++;
            end else begin
                exp_seg = ~seg_tab[word[4*k +: 4]];
                if (seg_n !== exp_seg) begin
                    $display("Error: %0d ns: digit %0d seg_n %b, expected %b",
                             $time, k, seg_n, exp_seg);
                    row_errs++;
                end
                seen[k] = 1'b1;
            end
        end
        if (seen != 8'hff) begin
            $display("Display scan missed digits, lit set %b", seen);
            row_errs++;
        end
    endtask

    ////////////////////////////////////////////////
    // One table row on the bus
    ////////////////////////////////////////////////

    task automatic run_row(input int i);
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [31:0] got;
        int          acc;
        row_errs = 0;
        sw = t_sw[i];
        repeat (t_idle[i]) @(negedge clk);
        wdata = t_wdata[i];
        if (t_rnd[i] && t_wr[i]) begin
            rand_state = next_random(rand_state);
            last_rand  = rand_state;
            wdata      = rand_state;
        end
        if (t_wr[i]) begin
            exp = '0;
        end else if (t_addr[i] == addr_cnt) begin
            exp = tmr_ms;
        end else if (t_rnd[i]) begin
            exp = (t_addr[i] == addr_led) ? (last_rand & 32'h0000_ffff) : last_rand;
        end else begin
            exp = t_exp[i];
        end
        rsp_ready = (t_stall[i] == 0);
        req_valid = 1'b1;
        req_write = t_wr[i];
        req_addr  = t_addr[i];
        req_wdata = wdata;
        while (!req_ready) @(negedge clk);
        acc = cycle + 1;
        @(negedge clk);
        req_valid = 1'b0;
        req_write = 1'b0;
        if (t_wr[i]) begin
            track_timer(t_addr[i], wdata, acc);
        end
        while (!rsp_valid) @(negedge clk);
        got = rsp_rdata;
        repeat (t_stall[i]) begin
            @(negedge clk);
            if (!rsp_valid || rsp_rdata !== got || req_ready) begin
                $display("Error: %0d ns: row %0d response moved under back-pressure", $time, i);
                row_errs++;
            end
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        if (got !== exp) begin
            $display("Error: %0d ns: row %0d read %h, expected %h", $time, i, got, exp);
            row_errs++;
        end
        if (rsp_valid) begin
            $display("Row %0d response was still pending after it was taken", i);
            row_errs++;
        end
        if (t_wr[i] && t_addr[i] == addr_led && led !== wdata[led_w-1:0]) begin
            $display("Error: %0d ns: led %h, expected %h", $time, led, wdata[led_w-1:0]);
            row_errs++;
        end
        if (t_wr[i] && t_addr[i] == addr_seg) begin
            check_display(wdata);
        end
        errors += row_errs;
        if (row_errs != 0) begin
            rows_failed++;
        end
        $display("Row %0d %s addr %h data %h: %s", i, t_wr[i] ? "write" : "read ",
                 t_addr[i], t_wr[i] ? wdata : got, (row_errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        rst_sync    = 1'b1;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b1;
        sw          = '0;
        errors      = 0;
        rows_failed = 0;
        row_errs    = 0;
        rand_state  = 32'hcc34_9bb0;
        last_rand   = '0;
        tmr_run     = 1'b0;
        tmr_start   = 0;
        tmr_ms      = '0;

        //       wr    addr      wdata          exp            sw    idle rnd stall
        add_row(1'b1, addr_led, 32'h1234_a5c3, 32'h0,         16'h0, 2,  1'b0, 0);
        add_row(1'b0, addr_led, 32'h0,         32'h0000_a5c3, 16'h0, 1,  1'b0, 0);
        add_row(1'b1, addr_led, 32'h0,         32'h0,         16'h0, 0,  1'b1, 0);
        add_row(1'b0, addr_led, 32'h0,         32'h0,         16'h0, 1,  1'b1, 2);
        add_row(1'b1, addr_seg, 32'h89ab_cdef, 32'h0,         16'h0, 1,  1'b0, 0);
        add_row(1'b0, addr_seg, 32'h0,         32'h89ab_cdef, 16'h0, 0,  1'b0, 3);
        add_row(1'b1, addr_seg, 32'h0,         32'h0,         16'h0, 0,  1'b1, 0);
        add_row(1'b0, addr_seg, 32'h0,         32'h0,         16'h0, 0,  1'b1, 0);
        add_row(1'b0, addr_sw,  32'h0,         32'h0000_5a3c, 16'h5a3c, 3, 1'b0, 0);
        add_row(1'b0, addr_sw,  32'h0,         32'h0000_ffff, 16'hffff, 4, 1'b0, 2);
        // Timer rows take their expected count from the reference model
        add_row(1'b0, addr_cnt, 32'h0,         32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b1, addr_cnt, cmd_start,     32'h0,         16'hffff, 1,  1'b0, 0);
        add_row(1'b1, addr_cnt, 32'h1234_5678, 32'h0,         16'hffff, 5,  1'b0, 0);
        add_row(1'b1, addr_cnt, cmd_stop,      32'h0,         16'hffff, 20, 1'b0, 0);
        add_row(1'b0, addr_cnt, 32'h0,         32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b0, addr_cnt, 32'h0,         32'h0,         16'hffff, 6,  1'b0, 0);
        add_row(1'b1, addr_cnt, 32'h0000_0001, 32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b0, addr_cnt, 32'h0,         32'h0,         16'hffff, 10, 1'b0, 4);
        add_row(1'b1, addr_cnt, cmd_start,     32'h0,         16'hffff, 1,  1'b0, 0);
        add_row(1'b1, addr_cnt, cmd_stop,      32'h0,         16'hffff, 40, 1'b0, 0);
        add_row(1'b0, addr_cnt, 32'h0,         32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b0, 4'h2,     32'h0,         32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b0, 4'h1,     32'h0,         32'h0,         16'hffff, 1,  1'b0, 2);
        add_row(1'b1, addr_led, 32'h0000_0f0f, 32'h0,         16'hffff, 0,  1'b0, 0);
        // Misaligned write in the LED word, which must leave the LED register alone
        add_row(1'b1, 4'h3,     32'hdead_beef, 32'h0,         16'hffff, 0,  1'b0, 0);
        add_row(1'b0, addr_led, 32'h0,         32'h0000_0f0f, 16'hffff, 0,  1'b0, 0);
        add_row(1'b0, 4'he,     32'h0,         32'h0,         16'hffff, 2,  1'b0, 0);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_sync = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end

        $display("Rows run %0d, rows failed %0d, errors %0d", n_rows, rows_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
